// ==== list.f ====
+incdir+design
design/fpu_pkg.sv
design/fpu_bus_regs.sv
design/fpu_sequencer.sv
design/fpu_add_sub.sv
design/fpu_shift_add_mul.sv
design/fpu.sv
bench/fpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the FPU testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module fpu_tb \
		-f list.f -Mdir obj_dir -o fpu_sim

run: compile
	@out="$$(./obj_dir/fpu_sim 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// ==== bench/fpu_tb.sv ====
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_tb;
  import fpu_pkg::*;

  localparam int WAIT_LIMIT = 100;

  logic                   clk;
  logic                   arst;
  logic [`FPU_BUS_W-1:0]  databus_in;
  logic [`FPU_BUS_W-1:0]  databus_out;
  logic [`FPU_ADDR_W-1:0] addr;
  logic                   cs;
  logic                   rd;
  logic                   wr;
  logic                   end_ack;
  logic                   cmd_end;
  logic                   busy;
  logic [15:0]            lfsr_state;

  fpu i_fpu (
    .clk         (clk),
    .arst        (arst),
    .databus_in  (databus_in),
    .databus_out (databus_out),
    .addr        (addr),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .end_ack     (end_ack),
    .cmd_end     (cmd_end),
    .busy        (busy)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("TEST FAILED");
    $display("%s", why);
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp)
      else abort_run($sformatf("mismatch %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  // ----------------------------------------------------------------------
  // handshake rules
  a_end_busy: assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy)
    else abort_run("cmd_end was high while busy was low");

  a_end_hold: assert property (@(posedge clk) disable iff (arst)
    $fell(cmd_end) |-> $past(end_ack))
    else abort_run("cmd_end fell without end_ack");

  a_busy_hold: assert property (@(posedge clk) disable iff (arst)
    $fell(busy) |-> $past(end_ack))
    else abort_run("busy fell without end_ack");

  a_release: assert property (@(posedge clk) disable iff (arst)
    cmd_end && end_ack |=> !busy && !cmd_end)
    else abort_run("busy or cmd_end still high the cycle after end_ack");

  // ----------------------------------------------------------------------
  // random source, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // signed count of halves, magnitude below 256
  function automatic int draw_halves();
    int mag;
    mag = int'(take_bits(8));
    return take_bits(1) != 0 ? -mag : mag;
  endfunction

  function automatic fp32_t draw_mul_operand();
    fp32_t f;
    f.sign = 1'(take_bits(1));
    f.exp  = 8'(112 + take_bits(5));
    f.frac = 23'(take_bits(23));
    return f;
  endfunction

  // ----------------------------------------------------------------------
  // reference values
  // n/2 as an IEEE single, exact while |n| stays below 2**24
  function automatic fp32_t halves_to_fp(input int n);
    fp32_t f;
    int    m;
    int    p;
    f = '0;
    if (n != 0) begin
      m = (n < 0) ? -n : n;
      p = 0;
      for (int i = 0; i < 24; i++) begin
        if (m[i]) begin
          p = i;
        end
      end
      f.sign = n < 0;
      f.exp  = 8'(p - 1 + `FPU_BIAS);
      f.frac = 23'(m << (23 - p));
    end
    return f;
  endfunction

  // truncated product, top 24 bits shifted once when the msb is clear
  function automatic fp32_t mul_expect(input fp32_t a, input fp32_t b);
    logic [47:0] prod;
    logic [23:0] top;
    fp32_t       r;
    if (a.exp == 0 || b.exp == 0) begin
      return '0;
    end
    prod   = 48'({1'b1, a.frac}) * 48'({1'b1, b.frac});
    top    = prod[47:24];
    r.sign = a.sign ^ b.sign;
    r.exp  = 8'(int'(a.exp) + int'(b.exp) - `FPU_BIAS + int'(top[23]));
    r.frac = top[23] ? top[22:0] : {top[21:0], 1'b0};
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // host bus, every task starts and ends 1 ns after a rising edge
  task automatic bus_write(input logic [`FPU_ADDR_W-1:0] a, input logic [7:0] d);
    addr       = a;
    databus_in = d;
    cs         = 1'b0;
    wr         = 1'b0;
    @(posedge clk);
    #1;
    cs = 1'b1;
    wr = 1'b1;
  endtask

  task automatic bus_read(input logic [`FPU_ADDR_W-1:0] a, output logic [7:0] d);
    addr = a;
    cs   = 1'b0;
    rd   = 1'b0;
    @(negedge clk);
    d = databus_out;
    @(posedge clk);
    #1;
    cs = 1'b1;
    rd = 1'b1;
  endtask

  task automatic write_word(input logic [`FPU_ADDR_W-1:0] base, input logic [31:0] w);
    for (int k = 0; k < 4; k++) begin
      bus_write(base + `FPU_ADDR_W'(k), w[8*k +: 8]);
    end
  endtask

  task automatic read_word(input logic [`FPU_ADDR_W-1:0] base, output logic [31:0] w);
    logic [7:0] b;
    for (int k = 0; k < 4; k++) begin
      bus_read(base + `FPU_ADDR_W'(k), b);
      w[8*k +: 8] = b;
    end
  endtask

  task automatic wait_cmd_end(input int limit);
    int n;
    n = 0;
    while (!cmd_end) begin
      if (n == limit) begin
        abort_run("timeout waiting for cmd_end");
      end
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  // start, wait for completion, acknowledge and fetch the result
  task automatic start_and_finish(output logic [31:0] r);
    bus_write(`FPU_ADDR_START, 8'h00);
    assert (!busy) else abort_run("busy rose in the same cycle as the start write");
    @(posedge clk);
    #1;
    assert (busy) else abort_run("busy did not rise one cycle after the start write");
    wait_cmd_end(WAIT_LIMIT);
    repeat (2) begin
      @(posedge clk);
      #1;
      assert (busy && cmd_end) else abort_run("busy or cmd_end dropped before end_ack");
    end
    end_ack = 1'b1;
    @(posedge clk);
    #1;
    end_ack = 1'b0;
    assert (!busy && !cmd_end) else abort_run("busy or cmd_end still high after end_ack");
    read_word(`FPU_ADDR_R0, r);
  endtask

  task automatic run_op(input fpu_op_e op, input fp32_t a, input fp32_t b,
                        output logic [31:0] r);
    write_word(`FPU_ADDR_A0, a);
    write_word(`FPU_ADDR_B0, b);
    bus_write(`FPU_ADDR_OP, 8'(op));
    start_and_finish(r);
  endtask

  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [7:0]  byte_v;
    fp32_t       a;
    fp32_t       b;
    fpu_op_e     op;
    int          na;
    int          nb;
    clk        = 1'b0;
    arst       = 1'b1;
    databus_in = '0;
    addr       = '0;
    cs         = 1'b1;
    rd         = 1'b1;
    wr         = 1'b1;
    end_ack    = 1'b0;
    lfsr_state = 16'd86;
    repeat (8) @(posedge clk);
    #1;
    arst = 1'b0;

    // reset state of the register map
    assert (!busy && !cmd_end) else abort_run("busy or cmd_end high after reset");
    read_word(`FPU_ADDR_A0, r);
    check_value("operand_a", r, 32'h3F80_0000);
    read_word(`FPU_ADDR_B0, r);
    check_value("operand_b", r, 32'h3F80_0000);
    bus_read(`FPU_ADDR_OP, byte_v);
    check_value("operation", 32'(byte_v), 32'(op_add));

    // exact add and sub on halves
    for (int i = 0; i < 16; i++) begin
      na = draw_halves();
      nb = draw_halves();
      op = (i % 2 == 1) ? op_sub : op_add;
      run_op(op, halves_to_fp(na), halves_to_fp(nb), r);
      check_value("result", r, (op == op_sub) ? halves_to_fp(na - nb) : halves_to_fp(na + nb));
    end

    // opposite signs cancel to all zero
    na = draw_halves() | 1;
    run_op(op_add, halves_to_fp(na), halves_to_fp(-na), r);
    check_value("result", r, 32'h0);
    run_op(op_sub, halves_to_fp(na), halves_to_fp(na), r);
    check_value("result", r, 32'h0);

    // multiply
    for (int i = 0; i < 10; i++) begin
      a = draw_mul_operand();
      b = draw_mul_operand();
      run_op(op_mul, a, b, r);
      check_value("result", r, mul_expect(a, b));
    end
    a = draw_mul_operand();
    run_op(op_mul, a, '0, r);
    check_value("result", r, 32'h0);

    // chaining through operand a
    run_op(op_add, halves_to_fp(6), halves_to_fp(3), r);
    check_value("result", r, halves_to_fp(9));
    read_word(`FPU_ADDR_A0, r);
    check_value("operand_a", r, halves_to_fp(9));
    write_word(`FPU_ADDR_B0, halves_to_fp(4));
    bus_write(`FPU_ADDR_OP, 8'(op_mul));
    start_and_finish(r);
    check_value("result", r, mul_expect(halves_to_fp(9), halves_to_fp(4)));

    // unsupported code leaves the operation alone
    bus_write(`FPU_ADDR_OP, 8'h05);
    bus_read(`FPU_ADDR_OP, byte_v);
    check_value("operation", 32'(byte_v), 32'(op_mul));

    $display("TEST OK");
    $finish;
  end

endmodule

// ==== design/fpu.sv ====
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu (
  input  logic                   clk,
  input  logic                   arst,
  input  logic [`FPU_BUS_W-1:0]  databus_in,
  output logic [`FPU_BUS_W-1:0]  databus_out,
  input  logic [`FPU_ADDR_W-1:0] addr,
  input  logic                   cs,
  input  logic                   rd,
  input  logic                   wr,
  input  logic                   end_ack,
  output logic                   cmd_end,
  output logic                   busy
);
  import fpu_pkg::*;

  fp32_t   operand_a;
  fp32_t   operand_b;
  fpu_op_e operation;
  fp32_t   add_result;
  fp32_t   mul_result;
  logic    start_req;
  logic    op_taken;
  logic    result_load;
  logic    add_start;
  logic    add_done;
  logic    mul_start;
  logic    mul_done;

  fpu_bus_regs i_bus_regs (
    .clk         (clk),
    .arst        (arst),
    .databus_in  (databus_in),
    .databus_out (databus_out),
    .addr        (addr),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .op_taken    (op_taken),
    .result_load (result_load),
    .add_result  (add_result),
    .mul_result  (mul_result),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .operation   (operation),
    .start_req   (start_req)
  );

  fpu_sequencer i_sequencer (
    .clk         (clk),
    .arst        (arst),
    .start_req   (start_req),
    .operation   (operation),
    .add_done    (add_done),
    .mul_done    (mul_done),
    .end_ack     (end_ack),
    .op_taken    (op_taken),
    .add_start   (add_start),
    .mul_start   (mul_start),
    .result_load (result_load),
    .busy        (busy),
    .cmd_end     (cmd_end)
  );

  fpu_add_sub i_add_sub (
    .clk       (clk),
    .arst      (arst),
    .start     (add_start),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .subtract  (operation == op_sub),
    .done      (add_done),
    .result    (add_result)
  );

  fpu_shift_add_mul i_mul (
    .clk       (clk),
    .arst      (arst),
    .start     (mul_start),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .done      (mul_done),
    .result    (mul_result)
  );

endmodule

// ==== design/fpu_shift_add_mul.sv ====
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_shift_add_mul (
  input  logic           clk,
  input  logic           arst,
  input  logic           start,
  input  fpu_pkg::fp32_t operand_a,
  input  fpu_pkg::fp32_t operand_b,
  output logic           done,
  output fpu_pkg::fp32_t result
);
  import fpu_pkg::*;

  localparam int SIG_W  = `FPU_FRAC_W + 1;
  localparam int STEPS  = `FPU_MUL_STEPS;
  localparam int STEP_W = $clog2(STEPS + 1);
  localparam int EXP_UW = `FPU_EXP_W + 2;

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_add,
    st_shift,
    st_assemble,
    st_done
  } mul_state_e;

  mul_state_e               state;
  fp_unpacked_t             ua;
  fp_unpacked_t             ub;
  logic [SIG_W-1:0]         multiplicand;
  // upper half gathers the product, multiplier shifts out of the lower half
  logic [2*SIG_W:0]         prod_mplr;
  logic [STEP_W-1:0]        step;
  logic [SIG_W-1:0]         prod_top;
  logic signed [EXP_UW-1:0] exp_sum;
  fp32_t                    res_next;

  assign ua       = unpack_fp(operand_a);
  assign ub       = unpack_fp(operand_b);
  assign prod_top = prod_mplr[2*SIG_W-1:SIG_W];
  assign exp_sum  = $signed(ua.exp) + $signed(ub.exp);
  assign done     = state == st_done;

  // ----------------------------------------------------------------------
  // control
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state <= st_idle;
      step  <= '0;
    end else begin
      case (state)
        st_idle: if (start) state <= st_load;
        st_load: begin
          step  <= '0;
          state <= st_add;
        end
        st_add: begin
          step  <= step + 1'b1;
          state <= st_shift;
        end
        st_shift: begin
          if (step == STEPS) begin
            state <= st_assemble;
          end else begin
            state <= st_add;
          end
        end
        st_assemble: state <= st_done;
        st_done:     if (!start) state <= st_idle;
        default:     state <= st_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    case (state)
      st_load: begin
        multiplicand <= ua.sig;
        prod_mplr    <= {(SIG_W+1)'(0), ub.sig};
      end
      st_add: begin
        if (prod_mplr[0]) begin
          prod_mplr[2*SIG_W:SIG_W] <= prod_mplr[2*SIG_W:SIG_W] + (SIG_W+1)'(multiplicand);
        end
      end
      st_shift:    prod_mplr <= prod_mplr >> 1;
      st_assemble: result    <= res_next;
      default: ;
    endcase
  end

  // ----------------------------------------------------------------------
  // assembly, product is truncated to its top bits
  always_comb begin
    if (ua.sig == '0 || ub.sig == '0) begin
      res_next = '0;
    end else begin
      res_next.sign = ua.sign ^ ub.sign;
      // top bit set means 1x.xxx, so bump the exponent
      res_next.exp  = `FPU_EXP_W'(exp_sum + prod_top[SIG_W-1] + `FPU_BIAS);
      res_next.frac = prod_top[SIG_W-1] ? prod_top[SIG_W-2:0]
                                        : {prod_top[SIG_W-3:0], 1'b0};
    end
  end

  a_step_bound: assert property (@(posedge clk) disable iff (arst)
    step <= STEPS)
    else $error("multiplier step counter overran");

endmodule

// ==== design/fpu_add_sub.sv ====
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_add_sub (
  input  logic           clk,
  input  logic           arst,
  input  logic           start,
  input  fpu_pkg::fp32_t operand_a,
  input  fpu_pkg::fp32_t operand_b,
  input  logic           subtract,
  output logic           done,
  output fpu_pkg::fp32_t result
);
  import fpu_pkg::*;

  localparam int SIG_W  = `FPU_FRAC_W + 1;
  localparam int G      = `FPU_GUARD_W;
  // two upper guard bits for sign and carry
  localparam int MANT_W = SIG_W + 2 + G;
  localparam int HIDDEN = SIG_W - 1 + G;
  localparam int EXP_UW = `FPU_EXP_W + 2;
  localparam int LEAD_W = $clog2(MANT_W);

  fp_unpacked_t             ua;
  fp_unpacked_t             ub;
  logic                     b_sign;
  logic signed [EXP_UW-1:0] exp_diff;
  logic signed [EXP_UW-1:0] exp_big;
  logic signed [EXP_UW-1:0] exp_norm;
  logic [EXP_UW-1:0]        shift_amt;
  logic [MANT_W-1:0]        ma;
  logic [MANT_W-1:0]        mb;
  logic [MANT_W-1:0]        sum;
  logic [MANT_W-1:0]        mag;
  logic [MANT_W-1:0]        norm;
  logic [LEAD_W-1:0]        lead;
  logic                     round_up;
  logic [SIG_W:0]           rounded;
  fp32_t                    res_next;

  // right shift, bits falling off are folded into a sticky lsb
  function automatic logic [MANT_W-1:0] align(input logic [MANT_W-1:0] m,
                                              input logic [EXP_UW-1:0] amt);
    logic [MANT_W-1:0] lost_mask;
    lost_mask = ~({MANT_W{1'b1}} << amt);
    return (m >> amt) | MANT_W'(|(m & lost_mask));
  endfunction

  assign ua       = unpack_fp(operand_a);
  assign ub       = unpack_fp(operand_b);
  assign b_sign   = ub.sign ^ subtract;
  assign exp_diff = $signed(ua.exp) - $signed(ub.exp);

  // ----------------------------------------------------------------------
  // alignment to the larger exponent
  // zero unpacks to the lowest exponent, so it always gets shifted
  always_comb begin
    if (exp_diff < 0) begin
      shift_amt = EXP_UW'(-exp_diff);
      exp_big   = ub.exp;
      ma        = align({2'b00, ua.sig, {G{1'b0}}}, shift_amt);
      mb        = {2'b00, ub.sig, {G{1'b0}}};
    end else begin
      shift_amt = EXP_UW'(exp_diff);
      exp_big   = ua.exp;
      ma        = {2'b00, ua.sig, {G{1'b0}}};
      mb        = align({2'b00, ub.sig, {G{1'b0}}}, shift_amt);
    end
  end

  // two's complement sum
  assign sum = (ua.sign ? -ma : ma) + (b_sign ? -mb : mb);
  assign mag = sum[MANT_W-1] ? -sum : sum;

  // ----------------------------------------------------------------------
  // normalize and round to nearest even
  always_comb begin
    lead = '0;
    for (int i = 0; i < MANT_W - 1; i++) begin
      if (mag[i]) begin
        lead = LEAD_W'(i);
      end
    end

    if (mag[MANT_W-2]) begin
      // carry out, one step right keeping sticky
      norm     = (mag >> 1) | MANT_W'(mag[0]);
      exp_norm = exp_big + 1'b1;
    end else begin
      norm     = mag << (HIDDEN - lead);
      exp_norm = exp_big - EXP_UW'(HIDDEN - lead);
    end

    round_up = norm[G-1] && ((|norm[G-2:0]) || norm[G]);
    rounded  = {1'b0, norm[HIDDEN:G]} + (SIG_W+1)'(round_up);

    if (sum == '0) begin
      res_next = '0;
    end else begin
      res_next.sign = sum[MANT_W-1];
      // rounding carry leaves an all-zero fraction
      res_next.exp  = `FPU_EXP_W'(exp_norm + rounded[SIG_W] + `FPU_BIAS);
      res_next.frac = rounded[SIG_W-2:0];
    end
  end

  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  // result held while done is high
  always_ff @(posedge clk) begin
    if (start && !done) begin
      result <= res_next;
    end
  end

  a_norm_exp: assert property (@(posedge clk) disable iff (arst)
    done && (result != '0) |-> result.exp != '0)
    else $error("nonzero sum with zero exponent field");

endmodule

// ==== design/fpu_sequencer.sv ====
`timescale 1ns/1ps

module fpu_sequencer (
  input  logic             clk,
  input  logic             arst,
  input  logic             start_req,
  input  fpu_pkg::fpu_op_e operation,
  input  logic             add_done,
  input  logic             mul_done,
  input  logic             end_ack,
  output logic             op_taken,
  output logic             add_start,
  output logic             mul_start,
  output logic             result_load,
  output logic             busy,
  output logic             cmd_end
);
  import fpu_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_dispatch,
    st_wait_unit,
    st_load,
    st_wait_ack
  } seq_state_e;

  seq_state_e state;
  seq_state_e state_next;
  logic       mul_sel;
  logic       take_mul;
  logic       unit_done;
  logic       unit_run;

  assign op_taken  = (state == st_idle) && start_req;
  // unit choice is frozen when the request is taken
  assign take_mul  = op_taken ? (operation == op_mul) : mul_sel;
  assign unit_done = mul_sel ? mul_done : add_done;
  assign unit_run  = (state_next == st_dispatch) || (state_next == st_wait_unit);

  always_comb begin
    state_next = state;
    case (state)
      st_idle:      if (start_req) state_next = st_dispatch;
      st_dispatch:  state_next = st_wait_unit;
      st_wait_unit: if (unit_done) state_next = st_load;
      // unit drops done one cycle after its start falls
      st_load:      if (!unit_done) state_next = st_wait_ack;
      st_wait_ack:  if (end_ack) state_next = st_idle;
      default:      state_next = st_idle;
    endcase
  end

  // ----------------------------------------------------------------------
  // outputs registered from the next state
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state       <= st_idle;
      mul_sel     <= 1'b0;
      add_start   <= 1'b0;
      mul_start   <= 1'b0;
      result_load <= 1'b0;
      busy        <= 1'b0;
      cmd_end     <= 1'b0;
    end else begin
      state       <= state_next;
      mul_sel     <= take_mul;
      add_start   <= unit_run && !take_mul;
      mul_start   <= unit_run && take_mul;
      result_load <= (state_next == st_load) && (state != st_load);
      busy        <= state_next != st_idle;
      cmd_end     <= state_next == st_wait_ack;
    end
  end

  // a unit counts as active from its start until its done falls
  a_one_unit: assert property (@(posedge clk) disable iff (arst)
    (add_start || add_done) |-> !(mul_start || mul_done))
    else $error("both arithmetic units active");

  a_end_busy: assert property (@(posedge clk) disable iff (arst)
    cmd_end |-> busy && !add_done && !mul_done)
    else $error("cmd_end without busy or with a unit still done");

endmodule

// ==== design/fpu_bus_regs.sv ====
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_bus_regs (
  input  logic                    clk,
  input  logic                    arst,
  input  logic [`FPU_BUS_W-1:0]   databus_in,
  output logic [`FPU_BUS_W-1:0]   databus_out,
  input  logic [`FPU_ADDR_W-1:0]  addr,
  input  logic                    cs,
  input  logic                    rd,
  input  logic                    wr,
  input  logic                    op_taken,
  input  logic                    result_load,
  input  fpu_pkg::fp32_t          add_result,
  input  fpu_pkg::fp32_t          mul_result,
  output fpu_pkg::fp32_t          operand_a,
  output fpu_pkg::fp32_t          operand_b,
  output fpu_pkg::fpu_op_e        operation,
  output logic                    start_req
);
  import fpu_pkg::*;

  localparam int BW = `FPU_BUS_W;
  localparam fp32_t FP_ONE = {1'b0, `FPU_EXP_W'(`FPU_BIAS), `FPU_FRAC_W'(0)};

  logic  host_wr;
  logic  host_rd;
  logic  op_valid;
  fp32_t result_q;
  fp32_t result_sel;

  // cs, rd and wr are active low
  assign host_wr = !cs && !wr;
  assign host_rd = !cs && !rd;

  // only add, sub and mul codes are accepted
  assign op_valid = (databus_in == BW'(op_add)) ||
                    (databus_in == BW'(op_sub)) ||
                    (databus_in == BW'(op_mul));

  assign result_sel = (operation == op_mul) ? mul_result : add_result;

  // ----------------------------------------------------------------------
  // host writes, start request, result capture
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      operand_a <= FP_ONE;
      operand_b <= FP_ONE;
      operation <= op_add;
      start_req <= 1'b0;
      result_q  <= '0;
    end else begin
      if (op_taken) begin
        start_req <= 1'b0;
      end
      if (host_wr) begin
        case (addr)
          `FPU_ADDR_A0:    operand_a[0*BW +: BW] <= databus_in;
          `FPU_ADDR_A1:    operand_a[1*BW +: BW] <= databus_in;
          `FPU_ADDR_A2:    operand_a[2*BW +: BW] <= databus_in;
          `FPU_ADDR_A3:    operand_a[3*BW +: BW] <= databus_in;
          `FPU_ADDR_B0:    operand_b[0*BW +: BW] <= databus_in;
          `FPU_ADDR_B1:    operand_b[1*BW +: BW] <= databus_in;
          `FPU_ADDR_B2:    operand_b[2*BW +: BW] <= databus_in;
          `FPU_ADDR_B3:    operand_b[3*BW +: BW] <= databus_in;
          `FPU_ADDR_OP: begin
            if (op_valid) begin
              operation <= fpu_op_e'(databus_in[3:0]);
            end
          end
          // a start while busy stays pending until idle
          `FPU_ADDR_START: start_req <= 1'b1;
          default: ;
        endcase
      end
      // completed result also lands in operand a for chaining
      if (result_load) begin
        result_q  <= result_sel;
        operand_a <= result_sel;
      end
    end
  end

  // ----------------------------------------------------------------------
  // read mux, zero when not selected
  always_comb begin
    databus_out = '0;
    if (host_rd) begin
      case (addr)
        `FPU_ADDR_A0: databus_out = operand_a[0*BW +: BW];
        `FPU_ADDR_A1: databus_out = operand_a[1*BW +: BW];
        `FPU_ADDR_A2: databus_out = operand_a[2*BW +: BW];
        `FPU_ADDR_A3: databus_out = operand_a[3*BW +: BW];
        `FPU_ADDR_B0: databus_out = operand_b[0*BW +: BW];
        `FPU_ADDR_B1: databus_out = operand_b[1*BW +: BW];
        `FPU_ADDR_B2: databus_out = operand_b[2*BW +: BW];
        `FPU_ADDR_B3: databus_out = operand_b[3*BW +: BW];
        `FPU_ADDR_OP: databus_out = BW'(operation);
        `FPU_ADDR_R0: databus_out = result_q[0*BW +: BW];
        `FPU_ADDR_R1: databus_out = result_q[1*BW +: BW];
        `FPU_ADDR_R2: databus_out = result_q[2*BW +: BW];
        `FPU_ADDR_R3: databus_out = result_q[3*BW +: BW];
        default:      databus_out = '0;
      endcase
    end
  end

endmodule

// ==== design/fpu_pkg.sv ====
`include "fpu_config.svh"

package fpu_pkg;

  // one IEEE single precision word
  typedef struct packed {
    logic                   sign;
    logic [`FPU_EXP_W-1:0]  exp;
    logic [`FPU_FRAC_W-1:0] frac;
  } fp32_t;

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_mul = 4'd2
  } fpu_op_e;

  // unbiased exponent, hidden bit made explicit
  typedef struct packed {
    logic                        sign;
    logic signed [`FPU_EXP_W+1:0] exp;
    logic [`FPU_FRAC_W:0]         sig;
  } fp_unpacked_t;

  function automatic fp_unpacked_t unpack_fp(input fp32_t f);
    fp_unpacked_t u;
    u.sign = f.sign;
    u.exp  = $signed({2'b00, f.exp}) - `FPU_BIAS;
    // zero exponent field means zero here, no subnormals
    u.sig  = {f.exp != '0, f.frac};
    return u;
  endfunction

endpackage

// ==== design/fpu_config.svh ====
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// host bus
`define FPU_BUS_W      8
`define FPU_ADDR_W     4

// single precision fields
`define FPU_EXP_W      8
`define FPU_FRAC_W     23
`define FPU_BIAS       127
`define FPU_GUARD_W    3
`define FPU_MUL_STEPS  24

// ----------------------------------------------------------------------
// register map
`define FPU_ADDR_A0    4'h0
`define FPU_ADDR_A1    4'h1
`define FPU_ADDR_A2    4'h2
`define FPU_ADDR_A3    4'h3
`define FPU_ADDR_B0    4'h4
`define FPU_ADDR_B1    4'h5
`define FPU_ADDR_B2    4'h6
`define FPU_ADDR_B3    4'h7
`define FPU_ADDR_OP    4'h8
// write launches the operation, read returns result byte 0
`define FPU_ADDR_START 4'h9
`define FPU_ADDR_R0    4'h9
`define FPU_ADDR_R1    4'hA
`define FPU_ADDR_R2    4'hB
`define FPU_ADDR_R3    4'hC

`endif
